// File: verilog.f
+incdir+common
common/if_pkg.sv
verilog/if_pc_select.sv
prefetch/if_prefetch_buffer.sv
prefetch/if_fetch_fifo.sv
verilog/if_id_register.sv
verilog/if_pc_check.sv
verilog/if_stage.sv
verification/if_stage_checker.sv
verification/tb_if_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch stage testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f verilog.f --top-module tb_if_stage -Mdir obj_dir -o tb_if_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_if_stage_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -Fxq "Test completed successfully" "$log"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

// File: verification/tb_if_stage.sv
// testbench top for the fetch stage
// clock, reset, bus memory model, decode-side driver and redirect stimulus

`timescale 1ns/100ps
`include "if_defs.svh"

module tb_if_stage;
  import if_pkg::*;

  localparam int NUM_REDIRECTS = 40;
  localparam int WAIT_LIMIT    = 300;
  // memory contents are the address scrambled with a key
  localparam logic [`IF_ADDR_W-1:0] DATA_KEY = 32'h5A3C_96E1;
  // window of addresses that answer with a bus error
  localparam logic [`IF_ADDR_W-1:0] ERR_LO   = 32'h0000_1C00;
  localparam logic [`IF_ADDR_W-1:0] ERR_HI   = 32'h0000_1E00;

  logic                  clk, rst_n;
  logic                  pc_set, req, id_in_ready, instr_valid_clear;
  pc_sel_e               pc_mux;
  exc_pc_sel_e           exc_pc_mux;
  exc_cause_t            exc_cause;
  logic [`IF_ADDR_W-1:0] boot_addr, branch_target, csr_mepc, csr_depc, csr_mtvec;
  logic                  instr_req, instr_gnt, instr_rvalid, instr_err;
  logic [`IF_ADDR_W-1:0] instr_addr, instr_rdata;
  logic                  instr_valid_id, instr_new_id, instr_fetch_err;
  logic [`IF_ADDR_W-1:0] instr_rdata_id, pc_id, pc_if;
  logic                  csr_mtvec_init, pc_mismatch_alert, if_busy;
  logic [`IF_ADDR_W-1:0] exp_pc;
  fetch_entry_t          exp_entry;
  int                    error_count, word_count, redirects;
  bit                    timed_out;
  // granted requests waiting for their response
  logic [`IF_ADDR_W-1:0] rsp_addr_q[$];
  int                    rsp_due_q[$];

  // expected bus word at one address
  function automatic fetch_entry_t ref_fetch(input logic [`IF_ADDR_W-1:0] addr);
    fetch_entry_t e;
    e.rdata = addr ^ DATA_KEY;
    e.addr  = addr;
    e.err   = (addr >= ERR_LO) && (addr < ERR_HI);
    return e;
  endfunction

  function automatic logic [`IF_ADDR_W-1:0] random_target();
    return 32'h0000_1000 + ($urandom_range(0, 1023) << 2);
  endfunction

  assign exp_entry = ref_fetch(exp_pc);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // bus slave with a grant delay of 0..3 cycles and in-order data 1..3 cycles later
  initial begin : bus_memory
    int           gnt_delay;
    int           cycle;
    fetch_entry_t rsp_word;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    instr_err    = 1'b0;
    gnt_delay    = -1;
    cycle        = 0;
    forever begin
      @(negedge clk);
      cycle++;
      // last grant was taken at the edge just passed
      if (instr_gnt) begin
        gnt_delay = -1;
      end
      instr_gnt = 1'b0;
      if (rst_n && instr_req) begin
        if (gnt_delay < 0) begin
          gnt_delay = $urandom_range(0, 3);
        end
        if (gnt_delay == 0) begin
          instr_gnt = 1'b1;
          rsp_addr_q.push_back(instr_addr);
          rsp_due_q.push_back(cycle + $urandom_range(1, 3));
        end else begin
          gnt_delay--;
        end
      end
      instr_rvalid = 1'b0;
      instr_rdata  = '0;
      instr_err    = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        rsp_word     = ref_fetch(rsp_addr_q[0]);
        instr_rvalid = 1'b1;
        instr_rdata  = rsp_word.rdata;
        instr_err    = rsp_word.err;
        void'(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end
    end
  end

  // decode side with random ready and a clear 1..3 cycles after each valid
  initial begin : decode_side
    int clear_wait;
    id_in_ready       = 1'b0;
    instr_valid_clear = 1'b0;
    clear_wait        = 0;
    forever begin
      @(negedge clk);
      id_in_ready       = ($urandom_range(0, 3) != 0);
      instr_valid_clear = 1'b0;
      if (clear_wait > 0) begin
        clear_wait--;
        instr_valid_clear = (clear_wait == 0);
      end else if (instr_valid_id) begin
        clear_wait = $urandom_range(1, 3);
      end
    end
  end

  // one-cycle redirect with fresh random operands
  task automatic redirect(input pc_sel_e kind, input bit into_err_window);
    pc_mux        = kind;
    exc_pc_mux    = exc_pc_sel_e'(2'($urandom_range(0, 3)));
    exc_cause.irq = (exc_pc_mux == EXC_PC_IRQ);
    exc_cause.id  = 5'($urandom_range(0, 31));
    boot_addr     = 32'h0000_1000 + ($urandom_range(0, 15) << 8);
    branch_target = into_err_window ? ERR_LO + ($urandom_range(0, 31) << 2) : random_target();
    csr_mepc      = random_target();
    csr_depc      = random_target();
    csr_mtvec     = random_target() | 32'($urandom_range(0, 3));
    pc_set        = 1'b1;
    @(negedge clk);
    pc_set        = 1'b0;
    redirects++;
  endtask

  task automatic wait_new_words(input int count);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < count && !timed_out) begin
      @(negedge clk);
      if (instr_new_id) begin
        seen++;
      end
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout waiting for %0d new instructions after redirect %0d at %0t",
                 count, redirects, $time);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin : stimulus
    pc_sel_e kind;
    void'($urandom(32'hb5f98398));
    rst_n         = 1'b0;
    pc_set        = 1'b0;
    req           = 1'b0;
    pc_mux        = PC_BOOT;
    exc_pc_mux    = EXC_PC_EXC;
    exc_cause     = '0;
    boot_addr     = 32'h0000_1000;
    branch_target = '0;
    csr_mepc      = '0;
    csr_depc      = '0;
    csr_mtvec     = '0;
    redirects     = 0;
    timed_out     = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    req = 1'b1;
    redirect(PC_BOOT, 1'b0);
    wait_new_words(6);
    for (int i = 0; i < NUM_REDIRECTS && !timed_out; i++) begin
      case ($urandom_range(0, 5))
        0, 1:    kind = PC_JUMP;
        2:       kind = PC_EXC;
        3:       kind = PC_ERET;
        4:       kind = PC_DRET;
        default: kind = PC_BOOT;
      endcase
      // every fifth redirect lands in the error window
      if (i % 5 == 4) begin
        kind = PC_JUMP;
      end
      repeat ($urandom_range(0, 3)) @(negedge clk);
      redirect(kind, i % 5 == 4);
      wait_new_words($urandom_range(2, 8));
    end
    repeat (10) @(negedge clk);
    $display("errors %0d, instructions checked %0d, redirects %0d, timeouts %0d",
             error_count, word_count, redirects, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  if_stage if_stage_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_pc_mux),
    .exc_cause_i (exc_cause), .boot_addr_i (boot_addr), .branch_target_i (branch_target),
    .csr_mepc_i (csr_mepc), .csr_depc_i (csr_depc), .csr_mtvec_i (csr_mtvec),
    .req_i (req), .id_in_ready_i (id_in_ready), .instr_valid_clear_i (instr_valid_clear),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .instr_err_i (instr_err),
    .instr_valid_id_o (instr_valid_id), .instr_new_id_o (instr_new_id),
    .instr_rdata_id_o (instr_rdata_id), .pc_id_o (pc_id),
    .instr_fetch_err_o (instr_fetch_err), .pc_if_o (pc_if),
    .csr_mtvec_init_o (csr_mtvec_init), .pc_mismatch_alert_o (pc_mismatch_alert),
    .if_busy_o (if_busy)
  );

  if_stage_checker stage_checker_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_pc_mux),
    .exc_cause_i (exc_cause), .boot_addr_i (boot_addr), .branch_target_i (branch_target),
    .csr_mepc_i (csr_mepc), .csr_depc_i (csr_depc), .csr_mtvec_i (csr_mtvec),
    .instr_valid_clear_i (instr_valid_clear), .instr_req_i (instr_req),
    .instr_gnt_i (instr_gnt), .instr_rvalid_i (instr_rvalid),
    .instr_valid_id_i (instr_valid_id), .instr_new_id_i (instr_new_id),
    .instr_rdata_id_i (instr_rdata_id), .pc_id_i (pc_id),
    .instr_fetch_err_i (instr_fetch_err), .csr_mtvec_init_i (csr_mtvec_init),
    .pc_mismatch_alert_i (pc_mismatch_alert), .pc_if_i (pc_if), .if_busy_i (if_busy),
    .exp_entry_i (exp_entry),
    .exp_pc_o (exp_pc), .error_count_o (error_count), .word_count_o (word_count)
  );

endmodule

// File: verification/if_stage_checker.sv
// fetch stage checker
// expected pc across redirects, decode outputs, valid/new flags, busy and alert

`timescale 1ns/100ps
`include "if_defs.svh"

module if_stage_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  pc_set_i,
  input  if_pkg::pc_sel_e       pc_mux_i,
  input  if_pkg::exc_pc_sel_e   exc_pc_mux_i,
  input  if_pkg::exc_cause_t    exc_cause_i,
  input  logic [`IF_ADDR_W-1:0] boot_addr_i,
  input  logic [`IF_ADDR_W-1:0] branch_target_i,
  input  logic [`IF_ADDR_W-1:0] csr_mepc_i,
  input  logic [`IF_ADDR_W-1:0] csr_depc_i,
  input  logic [`IF_ADDR_W-1:0] csr_mtvec_i,
  input  logic                  instr_valid_clear_i,
  input  logic                  instr_req_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic                  instr_valid_id_i,
  input  logic                  instr_new_id_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_id_i,
  input  logic [`IF_ADDR_W-1:0] pc_id_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  csr_mtvec_init_i,
  input  logic                  pc_mismatch_alert_i,
  input  logic [`IF_ADDR_W-1:0] pc_if_i,
  input  logic                  if_busy_i,
  input  if_pkg::fetch_entry_t  exp_entry_i,
  output logic [`IF_ADDR_W-1:0] exp_pc_o,
  output int                    error_count_o,
  output int                    word_count_o
);
  import if_pkg::*;

  logic                  booted;
  logic                  prev_valid;
  logic                  prev_clear;
  // head pc of the previous cycle, when the word now in decode was accepted
  logic [`IF_ADDR_W-1:0] prev_pc_if;
  // bus requests granted and still owed a response
  int                    bus_pending;
  logic                  exp_busy;
  int                    errors = 0;
  int                    words = 0;

  // where a redirect must land
  function automatic logic [`IF_ADDR_W-1:0] redirect_target(
    input pc_sel_e               sel,
    input exc_pc_sel_e           exc_sel,
    input exc_cause_t            cause,
    input logic [`IF_ADDR_W-1:0] boot,
    input logic [`IF_ADDR_W-1:0] jump,
    input logic [`IF_ADDR_W-1:0] mepc,
    input logic [`IF_ADDR_W-1:0] depc,
    input logic [`IF_ADDR_W-1:0] mtvec
  );
    logic [`IF_ADDR_W-1:0] base;
    logic [`IF_ADDR_W-1:0] target;
    base = mtvec & ~((32'd1 << `IF_VEC_ALIGN) - 32'd1);
    case (sel)
      PC_BOOT: target = (boot & 32'hFFFF_FF00) | 32'(`IF_BOOT_OFFSET);
      PC_JUMP: target = jump;
      PC_ERET: target = mepc;
      PC_DRET: target = depc;
      default: begin
        case (exc_sel)
          // one vector word per interrupt cause
          EXC_PC_IRQ:      target = base + 32'(cause.id) * 32'd4;
          EXC_PC_DBG_HALT: target = `IF_DM_HALT_ADDR;
          EXC_PC_DBG_EXC:  target = `IF_DM_EXC_ADDR;
          default:         target = base;
        endcase
      end
    endcase
    return target & ~32'd3;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    errors++;
  endtask

  // the stage is busy while a request waits for its grant or a response is owed
  assign exp_busy = instr_req_i || (bus_pending != 0);

  ////////////////////////////////////////////////////////////////////
  // everything is sampled at the rising edge before the design updates
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (instr_req_i || instr_valid_id_i || instr_new_id_i || csr_mtvec_init_i ||
          pc_mismatch_alert_i) begin
        report_failure("fetch stage outputs are not low during reset");
      end
      booted      <= 1'b0;
      bus_pending <= 0;
    end else begin
      if (csr_mtvec_init_i != (pc_set_i && pc_mux_i == PC_BOOT)) begin
        report_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_i),
                        32'(pc_set_i && pc_mux_i == PC_BOOT));
      end
      if (pc_mismatch_alert_i) begin
        report_failure("pc_mismatch_alert_o rose during correct operation");
      end
      if (if_busy_i != exp_busy) begin
        report_mismatch("if_busy_o", 32'(if_busy_i), 32'(exp_busy));
      end
      bus_pending <= bus_pending + int'(instr_req_i && instr_gnt_i) - int'(instr_rvalid_i);
      // valid and new flag relations
      if (instr_new_id_i && !instr_valid_id_i) begin
        report_failure("instr_new_id_o high while instr_valid_id_o is low");
      end
      if (prev_valid && !prev_clear && !instr_valid_id_i) begin
        report_failure("instr_valid_id_o dropped without a clear");
      end
      if (instr_valid_id_i && !prev_valid && !instr_new_id_i) begin
        report_failure("instr_valid_id_o rose without instr_new_id_o");
      end
      if (instr_new_id_i) begin
        words++;
        if (!booted) begin
          report_failure("new instruction before the boot redirect");
        end else begin
          if (pc_id_i != exp_pc_o) begin
            report_mismatch("pc_id_o", pc_id_i, exp_pc_o);
          end
          if (prev_pc_if != exp_pc_o) begin
            report_mismatch("pc_if_o", prev_pc_if, exp_pc_o);
          end
          if (instr_rdata_id_i != exp_entry_i.rdata) begin
            report_mismatch("instr_rdata_id_o", instr_rdata_id_i, exp_entry_i.rdata);
          end
          if (instr_fetch_err_i != exp_entry_i.err) begin
            report_mismatch("instr_fetch_err_o", 32'(instr_fetch_err_i),
                            32'(exp_entry_i.err));
          end
        end
        exp_pc_o <= exp_pc_o + 32'd4;
      end
      // a redirect in the same cycle wins over the increment
      if (pc_set_i) begin
        exp_pc_o <= redirect_target(pc_mux_i, exc_pc_mux_i, exc_cause_i, boot_addr_i,
                                    branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i);
        booted   <= 1'b1;
      end
    end
    prev_valid <= instr_valid_id_i;
    prev_clear <= instr_valid_clear_i;
    prev_pc_if <= pc_if_i;
  end

  assign error_count_o = errors;
  assign word_count_o  = words;

endmodule

// File: verilog/if_stage.sv
// instruction fetch stage top
// pc select -> prefetch -> fifo -> if-id register, with pc check

`timescale 1ns/100ps
`include "if_defs.svh"

module if_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // next pc control
  input  logic                  pc_set_i,
  input  if_pkg::pc_sel_e       pc_mux_i,
  input  if_pkg::exc_pc_sel_e   exc_pc_mux_i,
  input  if_pkg::exc_cause_t    exc_cause_i,
  input  logic [`IF_ADDR_W-1:0] boot_addr_i,
  input  logic [`IF_ADDR_W-1:0] branch_target_i,
  input  logic [`IF_ADDR_W-1:0] csr_mepc_i,
  input  logic [`IF_ADDR_W-1:0] csr_depc_i,
  input  logic [`IF_ADDR_W-1:0] csr_mtvec_i,
  input  logic                  req_i,
  input  logic                  id_in_ready_i,
  input  logic                  instr_valid_clear_i,
  // instruction bus
  output logic                  instr_req_o,
  output logic [`IF_ADDR_W-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_i,
  input  logic                  instr_err_i,
  // decode side
  output logic                  instr_valid_id_o,
  output logic                  instr_new_id_o,
  output logic [`IF_ADDR_W-1:0] instr_rdata_id_o,
  output logic [`IF_ADDR_W-1:0] pc_id_o,
  output logic                  instr_fetch_err_o,
  output logic [`IF_ADDR_W-1:0] pc_if_o,
  output logic                  csr_mtvec_init_o,
  output logic                  pc_mismatch_alert_o,
  output logic                  if_busy_o
);
  import if_pkg::*;

  logic [`IF_ADDR_W-1:0] fetch_addr;
  logic [`IF_CNT_W-1:0]  fifo_count;
  logic                  push;
  fetch_entry_t          push_entry;
  logic                  fetch_valid;
  fetch_entry_t          fetch_head;
  logic                  pop;
  id_instr_t             instr_id;

  if_pc_select pc_select_inst (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_o     (fetch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_prefetch_buffer prefetch_buffer_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_i   (fetch_addr),
    .fifo_count_i   (fifo_count),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .busy_o         (if_busy_o)
  );

  // the redirect doubles as the fifo flush
  if_fetch_fifo fetch_fifo_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (pc_set_i),
    .push_i       (push),
    .pop_i        (pop),
    .push_entry_i (push_entry),
    .valid_o      (fetch_valid),
    .head_o       (fetch_head),
    .count_o      (fifo_count)
  );

  if_id_register id_register_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_head_i        (fetch_head),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pop_o               (pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_id_o          (instr_id)
  );

  if_pc_check pc_check_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .accept_i            (pop),
    .pc_set_i            (pc_set_i),
    .fetch_valid_i       (fetch_valid),
    .pc_if_i             (fetch_head.addr),
    .pc_id_i             (instr_id.pc),
    .fetch_err_id_i      (instr_id.fetch_err),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // decode outputs straight from the pipeline register
  assign instr_rdata_id_o  = instr_id.rdata;
  assign pc_id_o           = instr_id.pc;
  assign instr_fetch_err_o = instr_id.fetch_err;
  assign pc_if_o           = fetch_head.addr;

endmodule

// File: verilog/if_pc_check.sv
// sequential pc check between fifo head and decode

`timescale 1ns/100ps
`include "if_defs.svh"

module if_pc_check (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  accept_i,
  input  logic                  pc_set_i,
  input  logic                  fetch_valid_i,
  input  logic [`IF_ADDR_W-1:0] pc_if_i,
  input  logic [`IF_ADDR_W-1:0] pc_id_i,
  input  logic                  fetch_err_id_i,
  output logic                  pc_mismatch_alert_o
);

  logic                  seq_q;
  logic [`IF_ADDR_W-1:0] pc_id_incr;

  // set once a word reached decode, dropped on any redirect
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= (seq_q | accept_i) & ~pc_set_i;
    end
  end

  assign pc_id_incr = pc_id_i + `IF_ADDR_W'(4);

  // no comparison behind a faulted fetch
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & ~fetch_err_id_i &
                               (pc_if_i != pc_id_incr);

endmodule

// File: verilog/if_id_register.sv
// if-id boundary: accept strobe, valid and new flags
// and the pipeline register handed to decode

`timescale 1ns/100ps
`include "if_defs.svh"

module if_id_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  input  if_pkg::fetch_entry_t fetch_head_i,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output logic                 pop_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_pkg::id_instr_t    instr_id_o
);

  logic accept;
  logic valid_q, valid_d;
  logic new_q;

  // a redirect in the same cycle squashes the head word
  assign accept = fetch_valid_i & id_in_ready_i & ~pc_set_i;
  assign pop_o  = accept;

  // valid stays up until decode clears it
  assign valid_d = accept | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one cycle per accepted word
      new_q   <= accept;
    end
  end

  // pipeline register, frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_id_o.rdata     <= fetch_head_i.rdata;
      instr_id_o.pc        <= fetch_head_i.addr;
      instr_id_o.fetch_err <= fetch_head_i.err;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// File: prefetch/if_fetch_fifo.sv
// fetched word fifo
// circular buffer of fetch entries, flushed on redirect

`timescale 1ns/100ps
`include "if_defs.svh"

module if_fetch_fifo (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  logic                 pop_i,
  input  if_pkg::fetch_entry_t push_entry_i,
  output logic                 valid_o,
  output if_pkg::fetch_entry_t head_o,
  output logic [`IF_CNT_W-1:0] count_o
);
  import if_pkg::*;

  fetch_entry_t         mem_q [`IF_FIFO_DEPTH];
  logic [`IF_PTR_W-1:0] rptr_q, wptr_q;
  logic [`IF_CNT_W-1:0] count_q;
  logic                 do_push;
  logic                 do_pop;

  // flush wins over a push in the same cycle
  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == `IF_PTR_W'(`IF_FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == `IF_PTR_W'(`IF_FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + `IF_CNT_W'(do_push) - `IF_CNT_W'(do_pop);
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= push_entry_i;
    end
  end

  // head is meaningful only while valid_o is high
  assign valid_o = (count_q != '0);
  assign head_o  = mem_q[rptr_q];
  assign count_o = count_q;

  ////////////////////////////////////////////////////////////////////
  // the prefetch engine and the decode side must respect fill level
  no_push_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    do_push |-> (count_q != `IF_CNT_W'(`IF_FIFO_DEPTH)))
    else $error("push into a full fetch fifo");

  no_pop_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (count_q != '0))
    else $error("pop from an empty fetch fifo");

endmodule

// File: prefetch/if_prefetch_buffer.sv
// instruction bus request engine
// tracks requests in flight, tags responses with their address
// and throws away responses owed to a flushed stream

`timescale 1ns/100ps
`include "if_defs.svh"

module if_prefetch_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  pc_set_i,
  input  logic [`IF_ADDR_W-1:0] fetch_addr_i,
  input  logic [`IF_CNT_W-1:0]  fifo_count_i,
  output logic                  instr_req_o,
  output logic [`IF_ADDR_W-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_i,
  input  logic                  instr_err_i,
  output logic                  push_o,
  output if_pkg::fetch_entry_t  push_entry_o,
  output logic                  busy_o
);

  logic                  fetch_en_q;
  logic                  req_q, req_d;
  logic                  stale_q, stale_d;
  logic [`IF_ADDR_W-1:0] req_addr_q, req_addr_d;
  logic [`IF_ADDR_W-1:0] next_addr_q, next_addr_d;
  logic [`IF_CNT_W-1:0]  out_q, out_d;
  logic [`IF_CNT_W-1:0]  disc_q, disc_d;
  logic [`IF_CNT_W:0]    occupancy;
  logic                  gnt_fire;
  logic                  launch;
  logic                  drop;
  logic [`IF_ADDR_W-1:0] aq_q [`IF_FIFO_DEPTH];
  logic [`IF_PTR_W-1:0]  aq_wptr_q, aq_rptr_q;

  assign gnt_fire = req_q & instr_gnt_i;
  // bus slot is free, nothing left waiting for a grant
  assign launch   = ~req_q | instr_gnt_i;

  // words already held plus words owed, the fifo part goes away on a flush
  assign occupancy = (pc_set_i ? '0 : {1'b0, fifo_count_i}) + {1'b0, out_q} +
                     {{`IF_CNT_W{1'b0}}, gnt_fire};

  // a response is dropped while old-stream words are still owed
  assign drop = instr_rvalid_i & ((disc_q != '0) | pc_set_i);

  always_comb begin
    next_addr_d = next_addr_q;
    if (gnt_fire && !stale_q) begin
      next_addr_d = req_addr_q + `IF_ADDR_W'(4);
    end
    // a redirect overrides the sequential address
    if (pc_set_i) begin
      next_addr_d = fetch_addr_i;
    end
  end

  always_comb begin
    if (launch) begin
      req_d      = req_i & (fetch_en_q | pc_set_i) & (occupancy < `IF_FIFO_DEPTH);
      req_addr_d = next_addr_d;
      stale_d    = 1'b0;
    end else begin
      // hold the pending request, it turns stale if a redirect passes it
      req_d      = 1'b1;
      req_addr_d = req_addr_q;
      stale_d    = stale_q | pc_set_i;
    end
  end

  assign out_d  = out_q + `IF_CNT_W'(gnt_fire) - `IF_CNT_W'(instr_rvalid_i);
  // on a redirect everything still in flight belongs to the old stream
  assign disc_d = pc_set_i ? out_d :
                  disc_q - `IF_CNT_W'(drop) + `IF_CNT_W'(gnt_fire & stale_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
      req_q      <= 1'b0;
      stale_q    <= 1'b0;
      out_q      <= '0;
      disc_q     <= '0;
      aq_wptr_q  <= '0;
      aq_rptr_q  <= '0;
    end else begin
      fetch_en_q <= fetch_en_q | pc_set_i;
      req_q      <= req_d;
      stale_q    <= stale_d;
      out_q      <= out_d;
      disc_q     <= disc_d;
      if (gnt_fire) begin
        aq_wptr_q <= (aq_wptr_q == `IF_PTR_W'(`IF_FIFO_DEPTH - 1)) ? '0 : aq_wptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        aq_rptr_q <= (aq_rptr_q == `IF_PTR_W'(`IF_FIFO_DEPTH - 1)) ? '0 : aq_rptr_q + 1'b1;
      end
    end
  end

  // addresses and the request address carry no reset
  always_ff @(posedge clk_i) begin
    req_addr_q  <= req_addr_d;
    next_addr_q <= next_addr_d;
    if (gnt_fire) begin
      aq_q[aq_wptr_q] <= req_addr_q;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;

  assign push_o             = instr_rvalid_i & ~drop;
  assign push_entry_o.rdata = instr_rdata_i;
  assign push_entry_o.addr  = aq_q[aq_rptr_q];
  assign push_entry_o.err   = instr_err_i;

  assign busy_o = req_q | (out_q != '0);

  ////////////////////////////////////////////////////////////////////
  // capacity shared with the fifo, bus address sanity
  occupancy_cap_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ({1'b0, out_q} + {1'b0, fifo_count_i}) <= `IF_FIFO_DEPTH)
    else $error("words in flight plus fifo entries exceed the fifo depth");

  req_addr_ok_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (!$isunknown(instr_addr_o) && instr_addr_o[1:0] == 2'b00))
    else $error("request address unknown or not word aligned");

endmodule

// File: verilog/if_pc_select.sv
// next fetch address selection
// exception vector mux and mtvec init strobe

`timescale 1ns/100ps
`include "if_defs.svh"

module if_pc_select (
  input  logic                  pc_set_i,
  input  if_pkg::pc_sel_e       pc_mux_i,
  input  if_pkg::exc_pc_sel_e   exc_pc_mux_i,
  input  if_pkg::exc_cause_t    exc_cause_i,
  input  logic [`IF_ADDR_W-1:0] boot_addr_i,
  input  logic [`IF_ADDR_W-1:0] branch_target_i,
  input  logic [`IF_ADDR_W-1:0] csr_mepc_i,
  input  logic [`IF_ADDR_W-1:0] csr_depc_i,
  input  logic [`IF_ADDR_W-1:0] csr_mtvec_i,
  output logic [`IF_ADDR_W-1:0] fetch_addr_o,
  output logic                  csr_mtvec_init_o
);
  import if_pkg::*;

  logic [`IF_ADDR_W-1:0] vec_base;
  logic [`IF_ADDR_W-1:0] exc_pc;
  logic [`IF_ADDR_W-1:0] next_pc;

  // mtvec with the low alignment bits forced to zero
  assign vec_base = {csr_mtvec_i[`IF_ADDR_W-1:`IF_VEC_ALIGN], {`IF_VEC_ALIGN{1'b0}}};

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:      exc_pc = vec_base;
      // vectored interrupt, one word per cause
      EXC_PC_IRQ:      exc_pc = vec_base + {{(`IF_ADDR_W - 7){1'b0}}, exc_cause_i.id, 2'b00};
      EXC_PC_DBG_HALT: exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC:  exc_pc = `IF_DM_EXC_ADDR;
      default:         exc_pc = vec_base;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: next_pc = {boot_addr_i[`IF_ADDR_W-1:8], `IF_BOOT_OFFSET};
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap or from debug mode
      PC_ERET: next_pc = csr_mepc_i;
      PC_DRET: next_pc = csr_depc_i;
      default: next_pc = {boot_addr_i[`IF_ADDR_W-1:8], `IF_BOOT_OFFSET};
    endcase
  end

  // fetches are always whole aligned words
  assign fetch_addr_o = {next_pc[`IF_ADDR_W-1:2], 2'b00};

  // mtvec is loaded from the boot base on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////////////
  // checks on the controller side of the interface
  always_comb begin
    boot_addr_aligned_a : assert final (boot_addr_i[7:0] == 8'h00)
      else $error("boot address not aligned to 256 bytes");
    if (pc_set_i) begin
      pc_mux_valid_a : assert final (!$isunknown(pc_mux_i) &&
                                     pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC,
                                                      PC_ERET, PC_DRET})
        else $error("pc_mux_i unknown or out of range on pc_set_i");
    end
  end

endmodule

// File: common/if_pkg.sv
// fetch stage types: next-pc selectors, exception cause
// and the records that move between fifo and decode

`include "if_defs.svh"

package if_pkg;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which vector an exception set goes to
  typedef enum logic [1:0] {
    EXC_PC_EXC      = 2'd0,
    EXC_PC_IRQ      = 2'd1,
    EXC_PC_DBG_HALT = 2'd2,
    EXC_PC_DBG_EXC  = 2'd3
  } exc_pc_sel_e;

  typedef struct packed {
    logic       irq;
    logic [4:0] id;
  } exc_cause_t;

  // one fetched word as it sits in the fifo
  typedef struct packed {
    logic [`IF_ADDR_W-1:0] rdata;
    logic [`IF_ADDR_W-1:0] addr;
    logic                  err;
  } fetch_entry_t;

  // the word as decode sees it
  typedef struct packed {
    logic [`IF_ADDR_W-1:0] rdata;
    logic [`IF_ADDR_W-1:0] pc;
    logic                  fetch_err;
  } id_instr_t;

endpackage

// File: common/if_defs.svh
// fetch stage widths, fifo sizing, vector alignment
// boot offset and debug entry addresses

`ifndef IF_DEFS_SVH
`define IF_DEFS_SVH

// address and instruction word width
`define IF_ADDR_W 32

// fifo entries, also the cap on entries plus requests in flight
`define IF_FIFO_DEPTH 2
// pointer and counter widths that go with the depth above
`define IF_PTR_W 1
`define IF_CNT_W 2

// low mtvec bits replaced by the vector offset
`define IF_VEC_ALIGN 8
`define IF_BOOT_OFFSET 8'h80

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR 32'h1A11_0808

`endif
